//--- common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // --------------------------------------------------
    // widths and RV32 field positions
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;   // architectural registers

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            alu_op_t;
    typedef logic [1:0]            branch_type_t;
    typedef logic [2:0]            instr_fmt_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLL = 4'd5;
    localparam alu_op_t ALU_SRL = 4'd6;
    localparam alu_op_t ALU_SRA = 4'd7;
    localparam alu_op_t ALU_SLT = 4'd8;

    // branch kinds seen by the predictor in EX
    localparam branch_type_t BR_JAL  = 2'd0;
    localparam branch_type_t BR_JALR = 2'd1;
    localparam branch_type_t BR_BEQ  = 2'd2;
    localparam branch_type_t BR_BNE  = 2'd3;   // also the idle value

    localparam instr_fmt_t FMT_R     = 3'd0;
    localparam instr_fmt_t FMT_I     = 3'd1;
    localparam instr_fmt_t FMT_S     = 3'd2;
    localparam instr_fmt_t FMT_SB    = 3'd3;
    localparam instr_fmt_t FMT_UJ    = 3'd4;
    localparam instr_fmt_t FMT_UNDEF = 3'd5;

    // --------------------------------------------------
    // control bundles
    // --------------------------------------------------
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;   // 1 = immediate operand
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } mem_ctrl_t;

    typedef struct packed {
        logic         is_branch;
        branch_type_t branch_type;
        word_t        pc;
        logic         prev_taken;
    } branch_info_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        logic      reg_write;
    } decoded_t;

    // addi x0, x0, 0 as seen by EX
    localparam ex_ctrl_t NOP_EX = '{alu_op: ALU_ADD, alu_src: 1'b1};

endpackage

`default_nettype wire

//--- decode/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  decode_pkg::word_t        instr,
    input  decode_pkg::word_t        pc,
    input  logic                     prev_taken,
    output decode_pkg::decoded_t     dec,
    output decode_pkg::branch_info_t dec_branch
);

    decode_pkg::instr_fmt_t   fmt;
    decode_pkg::alu_op_t      alu_op;
    decode_pkg::branch_type_t br_type;
    decode_pkg::reg_addr_t    rs1_f;
    decode_pkg::reg_addr_t    rs2_f;
    decode_pkg::reg_addr_t    rd_f;
    logic [2:0]               funct3;

    assign rs1_f  = instr[decode_pkg::RS1_LSB +: decode_pkg::REG_ADDR_W];
    assign rs2_f  = instr[decode_pkg::RS2_LSB +: decode_pkg::REG_ADDR_W];
    assign rd_f   = instr[decode_pkg::RD_LSB +: decode_pkg::REG_ADDR_W];
    assign funct3 = instr[decode_pkg::FUNCT3_LSB +: 3];

    // --------------------------------------------------
    // format from opcode bits 6..2
    // --------------------------------------------------
    always_comb begin
        case (instr[6:5])
            2'b00:   fmt = decode_pkg::FMT_I;   // loads, op-imm
            2'b01:   fmt = instr[4] ? decode_pkg::FMT_R : decode_pkg::FMT_S;
            2'b10:   fmt = decode_pkg::FMT_UNDEF;
            default: begin
                case (instr[3:2])
                    2'b00:   fmt = decode_pkg::FMT_SB;
                    2'b01:   fmt = decode_pkg::FMT_I;    // jalr
                    default: fmt = decode_pkg::FMT_UJ;
                endcase
            end
        endcase
    end

    // register fields and immediate, unused fields forced to 0
    always_comb begin
        dec.rs1 = '0;
        dec.rs2 = '0;
        dec.rd  = '0;
        dec.imm = '0;
        case (fmt)
            decode_pkg::FMT_R: begin
                dec.rs1 = rs1_f;
                dec.rs2 = rs2_f;
                dec.rd  = rd_f;
            end
            decode_pkg::FMT_I: begin
                dec.rs1 = rs1_f;
                dec.rd  = rd_f;
                dec.imm = {{20{instr[31]}}, instr[31:20]};
            end
            decode_pkg::FMT_S: begin
                dec.rs1 = rs1_f;
                dec.rs2 = rs2_f;
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            decode_pkg::FMT_SB: begin
                dec.rs1 = rs1_f;
                dec.rs2 = rs2_f;
                dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            decode_pkg::FMT_UJ: begin
                dec.rd  = rd_f;
                dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;   // undefined, all zero
        endcase
    end

    // --------------------------------------------------
    // alu operation
    // --------------------------------------------------
    always_comb begin
        alu_op = decode_pkg::ALU_ADD;
        if (!instr[3]) begin   // jal has no funct3
            case (funct3)
                3'b000: begin
                    if ((fmt == decode_pkg::FMT_R && instr[30]) || fmt == decode_pkg::FMT_SB)
                        alu_op = decode_pkg::ALU_SUB;   // sub, beq compare
                end
                3'b001:  alu_op = (fmt == decode_pkg::FMT_SB) ? decode_pkg::ALU_SUB
                                                              : decode_pkg::ALU_SLL;
                3'b010:  alu_op = (fmt == decode_pkg::FMT_R) ? decode_pkg::ALU_SLT
                                                             : decode_pkg::ALU_ADD;
                3'b100:  alu_op = decode_pkg::ALU_XOR;
                3'b101:  alu_op = instr[30] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                3'b110:  alu_op = decode_pkg::ALU_OR;
                3'b111:  alu_op = decode_pkg::ALU_AND;
                default: alu_op = decode_pkg::ALU_ADD;
            endcase
        end
    end

    // branch kind, only meaningful when is_branch
    always_comb begin
        br_type = decode_pkg::BR_BNE;
        if (instr[6:5] == 2'b11) begin
            case (instr[3:2])
                2'b00:   br_type = funct3[0] ? decode_pkg::BR_BNE : decode_pkg::BR_BEQ;
                2'b01:   br_type = decode_pkg::BR_JALR;
                2'b11:   br_type = decode_pkg::BR_JAL;
                default: br_type = decode_pkg::BR_BNE;
            endcase
        end
    end

    assign dec.ex.alu_op      = alu_op;
    assign dec.ex.alu_src     = !(fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_SB);
    assign dec.mem.mem_read   = (instr[6:4] == 3'b000);   // loads
    assign dec.mem.mem_write  = (instr[6:4] == 3'b010);   // stores
    assign dec.reg_write      = !(fmt == decode_pkg::FMT_S || fmt == decode_pkg::FMT_SB);

    assign dec_branch.is_branch   = (instr[6:5] == 2'b11);
    assign dec_branch.branch_type = br_type;
    assign dec_branch.pc          = pc;
    assign dec_branch.prev_taken  = prev_taken;

endmodule

`default_nettype wire

//--- decode/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  logic                  wb_en,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    input  logic                  memory_stall,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);

    decode_pkg::word_t regs [decode_pkg::NUM_REGS];
    logic              wr;

    // x0 never written, so it stays 0 from reset
    assign wr = wb_en && (wb_addr != '0) && !memory_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write-through so a same-cycle read sees the new word
    assign rdata1 = (wr && wb_addr == rs1) ? wb_data : regs[rs1];
    assign rdata2 = (wr && wb_addr == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

//--- decode/id_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     memory_stall,
    input  logic                     flush,
    input  decode_pkg::decoded_t     dec,
    input  decode_pkg::branch_info_t dec_branch,
    input  decode_pkg::word_t        rdata1,
    input  decode_pkg::word_t        rdata2,
    output decode_pkg::decoded_t     id_ex,
    output decode_pkg::word_t        data1,
    output decode_pkg::word_t        data2,
    output decode_pkg::branch_info_t branch,
    output logic                     pc_hold
);

    decode_pkg::decoded_t     nxt_dec;
    decode_pkg::branch_info_t nxt_branch;
    decode_pkg::word_t        nxt_data1;
    decode_pkg::word_t        nxt_data2;
    logic                     load_use;

    // --------------------------------------------------
    // load-use hazard detection
    // --------------------------------------------------
    // load now in EX targets a register the new instruction reads
    assign load_use = id_ex.mem.mem_read &&
                      (id_ex.rd == dec.rs1 || id_ex.rd == dec.rs2);

    assign pc_hold = load_use;   // fetch holds pc for one cycle

    // --------------------------------------------------
    // next state, flush before bubble
    // --------------------------------------------------
    always_comb begin
        nxt_dec    = dec;
        nxt_branch = dec_branch;
        nxt_data1  = rdata1;
        nxt_data2  = rdata2;
        if (flush) begin
            nxt_dec                = '0;
            nxt_dec.ex             = decode_pkg::NOP_EX;
            nxt_branch             = '0;
            nxt_branch.branch_type = decode_pkg::BR_BNE;
            nxt_data1              = '0;
            nxt_data2              = '0;
        end else if (load_use) begin
            // bubble: operands pass, controls killed
            nxt_dec.ex        = '0;
            nxt_dec.mem       = '0;
            nxt_dec.reg_write = 1'b0;
        end
    end

    // stage register, memory stall freezes everything
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex  <= '0;
            data1  <= '0;
            data2  <= '0;
            branch <= '0;
        end else if (!memory_stall) begin
            id_ex  <= nxt_dec;
            data1  <= nxt_data1;
            data2  <= nxt_data2;
            branch <= nxt_branch;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  decode_pkg::word_t        instr,
    input  decode_pkg::word_t        pc,
    input  logic                     prev_taken,
    input  logic                     memory_stall,
    input  logic                     flush,
    input  logic                     wb_en,        // from write-back stage
    input  decode_pkg::reg_addr_t    wb_addr,
    input  decode_pkg::word_t        wb_data,
    output decode_pkg::decoded_t     id_ex,
    output decode_pkg::word_t        data1,
    output decode_pkg::word_t        data2,
    output decode_pkg::branch_info_t branch,
    output logic                     pc_hold
);

    decode_pkg::decoded_t     dec;
    decode_pkg::branch_info_t dec_branch;
    decode_pkg::word_t        rdata1;
    decode_pkg::word_t        rdata2;

    instr_decoder u_decoder (
        .instr      (instr),
        .pc         (pc),
        .prev_taken (prev_taken),
        .dec        (dec),
        .dec_branch (dec_branch)
    );

    register_file u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1          (dec.rs1),
        .rs2          (dec.rs2),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .memory_stall (memory_stall),
        .rdata1       (rdata1),
        .rdata2       (rdata2)
    );

    id_ex_stage u_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .memory_stall (memory_stall),
        .flush        (flush),
        .dec          (dec),
        .dec_branch   (dec_branch),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .id_ex        (id_ex),
        .data1        (data1),
        .data2        (data2),
        .branch       (branch),
        .pc_hold      (pc_hold)
    );

endmodule

`default_nettype wire

//--- testbench/decode_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input decode_pkg::word_t        instr,
    input logic                     memory_stall,
    input logic                     flush,
    input decode_pkg::decoded_t     id_ex,
    input decode_pkg::word_t        data1,
    input decode_pkg::word_t        data2,
    input decode_pkg::branch_info_t branch,
    input logic                     pc_hold
);

    localparam decode_pkg::decoded_t NOP_DEC = '{rs1: '0, rs2: '0, rd: '0, imm: '0,
        ex: decode_pkg::NOP_EX, mem: '0, reg_write: 1'b0};
    localparam decode_pkg::branch_info_t NOP_BRANCH = '{is_branch: 1'b0,
        branch_type: decode_pkg::BR_BNE, pc: '0, prev_taken: 1'b0};

    int                    fail_count = 0;   // failed assertions so far
    decode_pkg::reg_addr_t src1;
    decode_pkg::reg_addr_t src2;
    logic                  load_use;

    // source fields as decoded, 0 where the format has none
    assign src1 = (instr[6:5] == 2'b10 || (instr[6:5] == 2'b11 && instr[3])) ? '0 : instr[19:15];
    assign src2 = (instr[6:5] == 2'b01 || (instr[6:5] == 2'b11 && instr[3:2] == 2'b00)) ?
                  instr[24:20] : '0;
    assign load_use = id_ex.mem.mem_read && (id_ex.rd == src1 || id_ex.rd == src2);

    // --------------------------------------------------
    // stall, flush and hazard rules
    // --------------------------------------------------
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        memory_stall |=> $stable(id_ex) && $stable(data1) && $stable(data2) && $stable(branch))
        else begin
            $error("stage outputs changed under memory stall");
            fail_count++;
        end

    flush_gives_nop: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !memory_stall |=> id_ex == NOP_DEC && data1 == '0 && data2 == '0 &&
                                   branch == NOP_BRANCH)
        else begin
            $error("flush did not load the nop state");
            fail_count++;
        end

    hold_on_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        pc_hold == load_use)
        else begin
            $error("pc_hold does not match the load-use condition");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_asserts u_asserts (.*);

`default_nettype wire

//--- testbench/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    localparam int MAX_CYCLES = 2000;   // roughly 3x the cycles used by all tests
    localparam int K_R    = 0;
    localparam int K_I    = 1;
    localparam int K_LD   = 2;
    localparam int K_S    = 3;
    localparam int K_SB   = 4;
    localparam int K_JAL  = 5;
    localparam int K_JALR = 6;

    logic                     clk;
    logic                     rst_n;
    decode_pkg::word_t        instr;
    decode_pkg::word_t        pc;
    logic                     prev_taken;
    logic                     memory_stall;
    logic                     flush;
    logic                     wb_en;
    decode_pkg::reg_addr_t    wb_addr;
    decode_pkg::word_t        wb_data;
    decode_pkg::decoded_t     id_ex;
    decode_pkg::word_t        data1;
    decode_pkg::word_t        data2;
    decode_pkg::branch_info_t branch;
    logic                     pc_hold;

    // reference model state
    decode_pkg::word_t        model_regs [decode_pkg::NUM_REGS];
    decode_pkg::decoded_t     exp_dec;
    decode_pkg::branch_info_t exp_br;
    decode_pkg::word_t        exp_d1;
    decode_pkg::word_t        exp_d2;
    decode_pkg::decoded_t     pend_dec;   // expected decode of the instruction on the inputs
    decode_pkg::branch_info_t pend_br;

    logic                  cfg_stall;
    logic                  cfg_flush;
    logic                  cfg_wen;
    decode_pkg::reg_addr_t cfg_waddr;
    decode_pkg::word_t     cfg_wdata;
    logic [31:0]           seed;
    int                    errors;
    int                    checks;
    int                    cycles;

    decode_stage DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .pc           (pc),
        .prev_taken   (prev_taken),
        .memory_stall (memory_stall),
        .flush        (flush),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .id_ex        (id_ex),
        .data1        (data1),
        .data2        (data2),
        .branch       (branch),
        .pc_hold      (pc_hold)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic decode_pkg::word_t next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[23:0], seed[31:24]};   // high bits to the bottom
    endfunction

    function automatic decode_pkg::alu_op_t expected_alu(input int kind, input logic [2:0] f3,
                                                         input logic b30);
        if (kind == K_JAL)
            return decode_pkg::ALU_ADD;
        case (f3)
            3'd0:    return ((kind == K_R && b30) || kind == K_SB) ? decode_pkg::ALU_SUB
                                                                   : decode_pkg::ALU_ADD;
            3'd1:    return (kind == K_SB) ? decode_pkg::ALU_SUB : decode_pkg::ALU_SLL;
            3'd2:    return (kind == K_R) ? decode_pkg::ALU_SLT : decode_pkg::ALU_ADD;
            3'd4:    return decode_pkg::ALU_XOR;
            3'd5:    return b30 ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    return decode_pkg::ALU_OR;
            3'd7:    return decode_pkg::ALU_AND;
            default: return decode_pkg::ALU_ADD;
        endcase
    endfunction

    task automatic verify(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("ERR %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // compares the registered outputs, then predicts the next ones
    task automatic check_and_predict();
        logic hazard;
        verify(id_ex === exp_dec, $sformatf("id_ex got %h exp %h", id_ex, exp_dec));
        verify(data1 === exp_d1 && data2 === exp_d2,
               $sformatf("data got %h/%h exp %h/%h", data1, data2, exp_d1, exp_d2));
        verify(branch === exp_br, $sformatf("branch got %h exp %h", branch, exp_br));
        hazard = exp_dec.mem.mem_read && (exp_dec.rd == pend_dec.rs1 || exp_dec.rd == pend_dec.rs2);
        verify(pc_hold === hazard, $sformatf("pc_hold got %b exp %b", pc_hold, hazard));
        if (!memory_stall) begin
            if (wb_en && wb_addr != 0)
                model_regs[wb_addr] = wb_data;
            if (flush) begin
                exp_dec = '0;
                exp_dec.ex = decode_pkg::NOP_EX;
                exp_br = '0;
                exp_br.branch_type = decode_pkg::BR_BNE;
                exp_d1 = '0;
                exp_d2 = '0;
            end else begin
                exp_dec = pend_dec;
                exp_br = pend_br;
                exp_d1 = model_regs[pend_dec.rs1];   // write-through already applied
                exp_d2 = model_regs[pend_dec.rs2];
                if (hazard) begin   // bubble
                    exp_dec.ex = '0;
                    exp_dec.mem = '0;
                    exp_dec.reg_write = 1'b0;
                end
            end
        end
    endtask

    // encodes one instruction from its fields and records what decode must give
    task automatic issue(input int kind, input decode_pkg::reg_addr_t rd,
                         input decode_pkg::reg_addr_t rs1, input decode_pkg::reg_addr_t rs2,
                         input logic [2:0] f3, input logic b30, input decode_pkg::word_t imm);
        decode_pkg::word_t ins;
        decode_pkg::word_t p;
        logic [2:0]        fn;
        fn = (kind == K_LD || kind == K_S) ? 3'b010 : (kind == K_JALR) ? 3'b000 : f3;
        p = next_random();
        pend_dec = '0;
        pend_br = '0;
        case (kind)
            K_R: begin
                ins = {1'b0, b30, 5'd0, rs2, rs1, fn, rd, 7'b0110011};
                pend_dec.rs1 = rs1;
                pend_dec.rs2 = rs2;
                pend_dec.rd = rd;
            end
            K_S: begin
                ins = {imm[11:5], rs2, rs1, fn, imm[4:0], 7'b0100011};
                pend_dec.rs1 = rs1;
                pend_dec.rs2 = rs2;
                pend_dec.imm = {{20{imm[11]}}, imm[11:0]};
            end
            K_SB: begin
                ins = {imm[12], imm[10:5], rs2, rs1, fn, imm[4:1], imm[11], 7'b1100011};
                pend_dec.rs1 = rs1;
                pend_dec.rs2 = rs2;
                pend_dec.imm = {{19{imm[12]}}, imm[12:1], 1'b0};
            end
            K_JAL: begin
                ins = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
                pend_dec.rd = rd;
                pend_dec.imm = {{11{imm[20]}}, imm[20:1], 1'b0};
            end
            default: begin   // op-imm, load and jalr share the I layout
                ins = {imm[11:0], rs1, fn, rd, (kind == K_LD) ? 7'b0000011 :
                       (kind == K_JALR) ? 7'b1100111 : 7'b0010011};
                pend_dec.rs1 = rs1;
                pend_dec.rd = rd;
                pend_dec.imm = {{20{imm[11]}}, imm[11:0]};
            end
        endcase
        pend_dec.ex.alu_op = expected_alu(kind, fn, ins[30]);
        pend_dec.ex.alu_src = !(kind == K_R || kind == K_SB);
        pend_dec.mem.mem_read = (kind == K_LD);
        pend_dec.mem.mem_write = (kind == K_S);
        pend_dec.reg_write = !(kind == K_S || kind == K_SB);
        pend_br.is_branch = (kind == K_SB || kind == K_JAL || kind == K_JALR);
        case (kind)
            K_SB:    pend_br.branch_type = fn[0] ? decode_pkg::BR_BNE : decode_pkg::BR_BEQ;
            K_JAL:   pend_br.branch_type = decode_pkg::BR_JAL;
            K_JALR:  pend_br.branch_type = decode_pkg::BR_JALR;
            default: pend_br.branch_type = decode_pkg::BR_BNE;
        endcase
        pend_br.pc = {p[31:2], 2'b00};
        pend_br.prev_taken = p[0];
        @(posedge clk);
        instr <= ins;
        pc <= pend_br.pc;
        prev_taken <= pend_br.prev_taken;
        memory_stall <= cfg_stall;
        flush <= cfg_flush;
        wb_en <= cfg_wen;
        wb_addr <= cfg_waddr;
        wb_data <= cfg_wdata;
        @(negedge clk);
        check_and_predict();
    endtask

    task automatic issue_random(input int kind);
        decode_pkg::word_t a;
        logic [2:0]        f3;
        a = next_random();
        f3 = a[14:12];
        if (kind == K_SB)
            f3 = {2'b00, a[12]};   // beq or bne
        else if (f3 == 3'd3)
            f3 = 3'd0;
        issue(kind, a[4:0], a[9:5], a[19:15], f3, a[30], next_random());
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-16s %s (%0d errors)", name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int mark;
        int asrt_fails;
        clk = 1'b0;
        rst_n = 1'b0;
        instr = 32'h0000_0013;   // addi x0, x0, 0
        pc = '0;
        prev_taken = 1'b0;
        memory_stall = 1'b0;
        flush = 1'b0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        cfg_stall = 1'b0;
        cfg_flush = 1'b0;
        cfg_wen = 1'b0;
        cfg_waddr = '0;
        cfg_wdata = '0;
        seed = 32;
        errors = 0;
        checks = 0;
        cycles = 0;
        for (int i = 0; i < decode_pkg::NUM_REGS; i++)
            model_regs[i] = '0;
        exp_dec = '0;
        exp_br = '0;
        exp_d1 = '0;
        exp_d2 = '0;
        pend_dec = '0;
        pend_dec.ex = decode_pkg::NOP_EX;
        pend_dec.reg_write = 1'b1;
        pend_br = '0;
        pend_br.branch_type = decode_pkg::BR_BNE;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_and_predict();   // outputs still at their reset value

        mark = errors;
        repeat (500) issue_random(int'(next_random() % 7));
        report_test("format decode", mark);

        mark = errors;
        cfg_wen = 1'b1;
        for (int r = 0; r < decode_pkg::NUM_REGS; r++) begin
            cfg_waddr = r[4:0];
            cfg_wdata = next_random();
            issue(K_R, 5'd1, r[4:0], 5'(r + 1), 3'd0, 1'b0, '0);   // same-cycle read
        end
        cfg_wen = 1'b0;
        repeat (64) issue_random(K_R);
        report_test("register file", mark);

        mark = errors;
        issue_random(K_I);
        cfg_stall = 1'b1;
        cfg_wen = 1'b1;
        cfg_waddr = 5'd12;
        cfg_wdata = next_random();
        repeat (4) issue_random(int'(next_random() % 7));
        cfg_stall = 1'b0;
        cfg_wen = 1'b0;
        issue(K_R, 5'd1, 5'd12, 5'd12, 3'd0, 1'b0, '0);
        report_test("stall", mark);

        mark = errors;
        issue_random(K_SB);
        cfg_flush = 1'b1;
        issue_random(K_LD);
        cfg_flush = 1'b0;
        issue_random(K_R);
        cfg_stall = 1'b1;   // stall beats flush
        cfg_flush = 1'b1;
        issue_random(K_JAL);
        issue_random(K_R);
        cfg_stall = 1'b0;
        cfg_flush = 1'b0;
        issue_random(K_I);
        report_test("flush", mark);

        mark = errors;
        issue(K_LD, 5'd9, 5'd2, 5'd0, 3'd0, 1'b0, 32'h0000_0010);
        issue(K_R, 5'd4, 5'd9, 5'd5, 3'd0, 1'b0, '0);
        issue(K_LD, 5'd10, 5'd3, 5'd0, 3'd0, 1'b0, 32'h0000_0004);
        issue(K_I, 5'd6, 5'd3, 5'd0, 3'd0, 1'b0, 32'h0000_0001);   // unrelated source
        issue(K_LD, 5'd11, 5'd1, 5'd0, 3'd0, 1'b0, '0);
        issue(K_S, 5'd0, 5'd1, 5'd11, 3'd0, 1'b0, 32'h0000_0008);   // hazard on rs2
        report_test("load-use", mark);

        mark = errors;
        issue(K_SB, 5'd0, 5'd3, 5'd4, 3'd0, 1'b0, 32'h0000_0ff0);
        issue(K_SB, 5'd0, 5'd5, 5'd6, 3'd1, 1'b0, 32'h0000_1008);
        issue(K_JAL, 5'd1, 5'd0, 5'd0, 3'd0, 1'b0, 32'h0010_0400);
        issue(K_JALR, 5'd1, 5'd7, 5'd0, 3'd0, 1'b0, 32'h0000_0800);
        issue_random(K_R);
        report_test("branch info", mark);

        issue(K_I, 5'd0, 5'd0, 5'd0, 3'd0, 1'b0, '0);   // drain the last prediction
        asrt_fails = DUT.u_asserts.fail_count;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/decode_pkg.sv
decode/instr_decoder.sv
decode/register_file.sv
decode/id_ex_stage.sv
hdl/decode_stage.sv
testbench/decode_stage_asserts.sv
testbench/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - common/decode_pkg.sv
  - decode/instr_decoder.sv
  - decode/register_file.sv
  - decode/id_ex_stage.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - testbench/decode_stage_asserts.sv
      - testbench/tb_decode_stage.sv
